// ==== joyRocker.f ====
design/joyPkg.sv
design/pollTimer.sv
design/spiByteEngine.sv
design/jstkFrameCtrl.sv
design/axisRepeat.sv
design/joyRocker.sv
test/joy_props.sv
test/joyTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module joyTb -f joyRocker.f -o joySim

out=$(./obj_dir/joySim)
echo "$out"

# Pass only if the testbench reported it
echo "$out" | grep -q "ALL CHECKS PASSED"

// ==== test/joyTb.sv ====
`timescale 1ns/10ps

module joyTb;
    import joyPkg::*;

    logic      CLK;
    logic      RST;
    logic      miso;
    spiPins_t  pins;
    joyState_t joy;
    dirPulse_t dir;

    // Joystick seen by the slave model
    logic [POS_W-1:0] stickX;
    logic [POS_W-1:0] stickY;
    logic             trigger;
    logic             thumb;
    logic [39:0]      txSr;             // Bytes still to go out
    logic             loaded = 1'b0;
    logic             sclkQ = 1'b0;
    logic             ssQ = 1'b1;
    joyState_t        expJoy;           // Snapshot at frame start
    logic [31:0]      lfsr = 32'h1b21;
    int               cyc = 0;
    int               errCnt = 0;
    int               timeoutCnt = 0;
    int               frameCnt = 0;
    int               chkDelay = 0;
    int               pulseCnt [4];     // Per dir bit, left is 3

    joyRocker dut_i (.CLK, .RST, .miso, .pins, .joy, .dir);

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;              // 40 ns period

    always @(posedge CLK) cyc <= cyc + 1;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};    // One step per bit
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Byte order on the wire, first byte on top
    function automatic logic [39:0] buildFrame(input logic [POS_W-1:0] x,
                                               input logic [POS_W-1:0] y,
                                               input logic trig, input logic thb);
        return {y[7:0], 6'b0, y[9:8], x[7:0], 6'b0, x[9:8], 6'b0, thb, trig};
    endfunction

    // Expected decode
    function automatic joyState_t refJoy(input logic [POS_W-1:0] x, input logic [POS_W-1:0] y,
                                         input logic trig, input logic thb);
        return '{x: x, y: y, trigger: trig, thumb: thb};
    endfunction

    function automatic string dirName(input int idx);
        case (idx)
            3:       return "left";
            2:       return "right";
            1:       return "up";
            default: return "down";
        endcase
    endfunction

    task automatic reportErr(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %s expected %0h actual %0h", name, exp, act);
        errCnt++;
    endtask

    task automatic noteTimeout(input string what);
        $display("Timeout while waiting for %s", what);
        timeoutCnt++;
    endtask

    // ====================
    // SPI slave model
    // ====================
    always @(negedge CLK) begin
        if (pins.ss) begin
            loaded = 1'b0;
            miso   = 1'b0;
        end else if (!loaded) begin
            txSr   = buildFrame(stickX, stickY, trigger, thumb);
            expJoy = refJoy(stickX, stickY, trigger, thumb);
            loaded = 1'b1;
            miso   = txSr[39];          // MSB ready before first rise
        end else if (sclkQ && !pins.sclk) begin
            txSr = {txSr[38:0], 1'b0};  // Next bit after falling sclk
            miso = txSr[39];
        end
        sclkQ = pins.sclk;
    end

    // Compare joy two cycles after ss rises
    always @(negedge CLK) begin
        if (!pins.ss && pins.mosi !== 1'b0)
            reportErr("mosi", 0, pins.mosi);    // Zero all through the frame
        if (chkDelay == 1) begin
            frameCnt++;
            if (joy !== expJoy)
                reportErr("frame decode", 32'(expJoy), 32'(joy));
        end
        if (chkDelay > 0)
            chkDelay--;
        if (!ssQ && pins.ss && !RST)
            chkDelay = 2;
        ssQ = pins.ss;
    end

    // ====================
    // Stimulus helpers
    // ====================
    task automatic stepCycle();
        @(negedge CLK);
        for (int i = 0; i < 4; i++) begin
            if (dir[i])
                pulseCnt[i]++;
        end
    endtask

    task automatic stepCycles(input int n);
        repeat (n) stepCycle();
    endtask

    task automatic clearCounts();
        for (int i = 0; i < 4; i++)
            pulseCnt[i] = 0;
    endtask

    task automatic waitSs(input logic level, input int limit);
        int n;
        n = 0;
        while (pins.ss !== level && n < limit) begin
            stepCycle();
            n++;
        end
        if (pins.ss !== level)
            noteTimeout(level ? "ss to rise" : "ss to fall");
    endtask

    // Whole new frame, then joy settled
    task automatic nextFrame();
        waitSs(1'b0, 2 * POLL_CYCLES);
        waitSs(1'b1, POLL_CYCLES);
        stepCycles(2);
    endtask

    // Only between frames, so the slave snapshot stays clean
    task automatic setStick(input logic [POS_W-1:0] x, input logic [POS_W-1:0] y,
                            input logic trig, input logic thb);
        waitSs(1'b1, POLL_CYCLES);
        stickX  = x;
        stickY  = y;
        trigger = trig;
        thumb   = thb;
    endtask

    task automatic waitPulse(input int idx, input int limit, output int at);
        int n;
        n = 0;
        do begin
            stepCycle();
            n++;
        end while (!dir[idx] && n < limit);
        at = cyc;
        if (!dir[idx])
            noteTimeout({dirName(idx), " pulse"});
    endtask

    task automatic checkQuiet(input string name);
        for (int i = 0; i < 4; i++) begin
            if (pulseCnt[i] != 0)
                reportErr({name, " ", dirName(i)}, 0, pulseCnt[i]);
        end
    endtask

    task automatic checkIdle(input string name);
        if (pins.ss !== 1'b1)
            reportErr({name, " ss"}, 1, pins.ss);
        if (pins.sclk !== 1'b0)
            reportErr({name, " sclk"}, 0, pins.sclk);
        if (dir !== 4'b0)
            reportErr({name, " dir"}, 0, dir);
    endtask

    task automatic returnCenter();
        setStick(CENTER_POS, CENTER_POS, 1'b0, 1'b0);
        nextFrame();
        stepCycles(3);                  // Through posQ and the axis FSM
    endtask

    // One first pulse on idx only
    task automatic checkMapping(input logic [POS_W-1:0] x, input logic [POS_W-1:0] y,
                                input int idx);
        int t;
        setStick(x, y, 1'b0, 1'b0);
        clearCounts();
        waitPulse(idx, 3 * POLL_CYCLES, t);
        stepCycles(2 * POLL_CYCLES);    // Still short of the hold delay
        for (int i = 0; i < 4; i++) begin
            if (pulseCnt[i] != (i == idx ? 1 : 0))
                reportErr({"mapping ", dirName(i)}, (i == idx ? 1 : 0), pulseCnt[i]);
        end
        returnCenter();
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [POS_W-1:0] rx;
        logic [POS_W-1:0] ry;
        logic             rt;
        logic             rh;
        int               t0;
        int               t1;
        int               t2;
        int               t3;

        RST     = 1'b1;
        miso    = 1'b0;
        stickX  = CENTER_POS;
        stickY  = CENTER_POS;
        trigger = 1'b0;
        thumb   = 1'b0;
        clearCounts();

        // Reset state, 5 cycles held
        for (int i = 0; i < 5; i++) begin
            stepCycle();
            checkIdle("reset");
        end
        RST = 1'b0;
        for (int i = 0; i < 4; i++) begin
            stepCycle();
            checkIdle("after reset");
        end

        // Frame decode with random sticks
        for (int k = 0; k < 20; k++) begin
            rx = POS_W'(takeBits(POS_W));
            ry = POS_W'(takeBits(POS_W));
            rt = 1'(takeBits(1));
            rh = 1'(takeBits(1));
            setStick(rx, ry, rt, rh);
            nextFrame();
        end

        // Centre band, limits inclusive
        returnCenter();
        clearCounts();
        for (int k = 0; k < 3; k++) begin
            if (k == 0) begin
                rx = POS_W'(LOW_LIMIT);
                ry = POS_W'(HIGH_LIMIT);
            end else if (k == 1) begin
                rx = POS_W'(HIGH_LIMIT);
                ry = POS_W'(LOW_LIMIT);
            end else begin
                rx = POS_W'(LOW_LIMIT + takeBits(9) % (HIGH_LIMIT - LOW_LIMIT + 1));
                ry = POS_W'(LOW_LIMIT + takeBits(9) % (HIGH_LIMIT - LOW_LIMIT + 1));
            end
            setStick(rx, ry, 1'b0, 1'b0);
            nextFrame();
        end
        stepCycles(3);                  // Last frame through the axis FSM
        checkQuiet("centre band");

        // Hold right, measure first, hold and repeat gaps
        setStick(10'd900, CENTER_POS, 1'b0, 1'b0);
        clearCounts();
        waitPulse(2, 3 * POLL_CYCLES, t0);
        waitPulse(2, HOLD_CYCLES + 8, t1);
        if (t1 - t0 != HOLD_CYCLES)
            reportErr("hold gap", HOLD_CYCLES, t1 - t0);
        waitPulse(2, REPEAT_CYCLES + 8, t2);
        if (t2 - t1 != REPEAT_CYCLES)
            reportErr("repeat gap 1", REPEAT_CYCLES, t2 - t1);
        waitPulse(2, REPEAT_CYCLES + 8, t3);
        if (t3 - t2 != REPEAT_CYCLES)
            reportErr("repeat gap 2", REPEAT_CYCLES, t3 - t2);
        if (pulseCnt[2] != 4)
            reportErr("right count", 4, pulseCnt[2]);
        pulseCnt[2] = 0;
        checkQuiet("hold right");

        // Release back to centre
        returnCenter();
        clearCounts();
        stepCycles(REPEAT_CYCLES + POLL_CYCLES);
        checkQuiet("release");

        checkMapping(10'd80, CENTER_POS, 3);     // left
        checkMapping(CENTER_POS, 10'd950, 0);    // down
        checkMapping(CENTER_POS, 10'd40, 1);     // up

        if (frameCnt < 20)
            reportErr("frames checked", 20, frameCnt);

        $display("Summary: %0d frames checked, %0d errors, %0d timeouts",
                 frameCnt, errCnt, timeoutCnt);
        if (errCnt == 0 && timeoutCnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== test/joy_props.sv ====
`timescale 1ns/10ps

module joyProps (
    input logic              CLK,
    input logic              RST,
    input logic              ss,
    input logic              sclk,
    input logic              busy,
    input logic              byteDone,
    input joyPkg::dirPulse_t dir
);

    // ====================
    // SPI link
    // ====================
    sclkParked: assert property (@(posedge CLK) disable iff (RST) ss |-> !sclk)
        else $error("sclk high while slave deselected");

    // Done only as busy falls, inside a selected frame
    doneAfterBusy: assert property (@(posedge CLK) disable iff (RST)
                                    byteDone |-> $past(busy) && !busy && !ss)
        else $error("byteDone outside a transfer or outside a frame");

    // ====================
    // Direction pulses
    // ====================
    xExclusive: assert property (@(posedge CLK) disable iff (RST) !(dir.left && dir.right))
        else $error("left and right pulses together");

    yExclusive: assert property (@(posedge CLK) disable iff (RST) !(dir.up && dir.down))
        else $error("up and down pulses together");

endmodule

bind joyRocker joyProps props_i (.CLK, .RST, .ss, .sclk, .busy, .byteDone, .dir);

// ==== design/joyRocker.sv ====
`timescale 1ns/10ps

module joyRocker (
    input  logic              CLK,
    input  logic              RST,
    input  logic              miso,
    output joyPkg::spiPins_t  pins,
    output joyPkg::joyState_t joy,
    output joyPkg::dirPulse_t dir
);
    import joyPkg::*;

    logic        bitTick;
    logic        pollReq;
    logic        byteStart;
    logic        busy;
    logic        byteDone;
    logic [7:0]  rxByte;
    logic        ss;
    logic        sclk;
    logic        mosi;
    logic        frameValid;
    logic [39:0] frame;
    logic        xLow;
    logic        xHigh;
    logic        yLow;
    logic        yHigh;
    joyState_t   decoded;

    pollTimer timer_i (.CLK, .RST, .bitTick, .pollReq);

    spiByteEngine spi_i (
        .CLK, .RST, .bitTick, .byteStart, .miso,
        .sclk, .mosi, .busy, .byteDone, .rxByte
    );

    jstkFrameCtrl ctrl_i (
        .CLK, .RST, .pollReq, .busy, .byteDone, .rxByte,
        .byteStart, .ss, .frameValid, .frame
    );

    // ====================
    // Frame decode
    // ====================
    assign decoded = '{x:       {frame[9:8], frame[23:16]},     // byte3 high, byte2 low
                       y:       {frame[25:24], frame[39:32]},   // byte1 high, byte0 low
                       trigger: frame[0],
                       thumb:   frame[1]};

    always_ff @(posedge CLK) begin
        if (RST)
            joy <= '{x: CENTER_POS, y: CENTER_POS, trigger: 1'b0, thumb: 1'b0};
        else if (frameValid)
            joy <= decoded;     // Hold until next frame
    end

    axisRepeat xAxis_i (.CLK, .RST, .pos(joy.x), .lowPulse(xLow), .highPulse(xHigh));
    axisRepeat yAxis_i (.CLK, .RST, .pos(joy.y), .lowPulse(yLow), .highPulse(yHigh));

    assign dir  = '{left: xLow, right: xHigh, up: yLow, down: yHigh};
    assign pins = '{ss: ss, sclk: sclk, mosi: mosi};

endmodule

// ==== design/axisRepeat.sv ====
`timescale 1ns/10ps

module axisRepeat (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic [joyPkg::POS_W-1:0] pos,
    output logic                   lowPulse,
    output logic                   highPulse
);
    import joyPkg::*;

    axisState_t         state;
    logic [DWELL_W-1:0] dwell;      // Cycles since last pulse
    logic [POS_W-1:0]   posQ;
    logic               isLow;
    logic               isHigh;

    always_ff @(posedge CLK) begin
        posQ <= pos;
    end

    assign isLow  = (posQ < POS_W'(LOW_LIMIT));
    assign isHigh = (posQ > POS_W'(HIGH_LIMIT));

    // ====================
    // Press, hold, repeat
    // ====================
    always_ff @(posedge CLK) begin
        if (RST) begin
            state     <= AxCenter;
            dwell     <= '0;
            lowPulse  <= 1'b0;
            highPulse <= 1'b0;
        end else begin
            lowPulse  <= 1'b0;
            highPulse <= 1'b0;
            dwell     <= dwell + 1'b1;
            case (state)
                AxCenter: begin
                    dwell <= '0;
                    if (isLow) begin
                        state    <= AxLowWait;
                        lowPulse <= 1'b1;   // First pulse
                    end else if (isHigh) begin
                        state     <= AxHighWait;
                        highPulse <= 1'b1;
                    end
                end
                AxLowWait: begin
                    if (!isLow) begin
                        state <= AxCenter;  // Released, no pulse
                    end else if (dwell == DWELL_W'(HOLD_CYCLES - 1)) begin
                        state    <= AxLowRepeat;
                        lowPulse <= 1'b1;
                        dwell    <= '0;
                    end
                end
                AxLowRepeat: begin
                    if (!isLow) begin
                        state <= AxCenter;
                    end else if (dwell == DWELL_W'(REPEAT_CYCLES - 1)) begin
                        lowPulse <= 1'b1;
                        dwell    <= '0;
                    end
                end
                AxHighWait: begin
                    if (!isHigh) begin
                        state <= AxCenter;
                    end else if (dwell == DWELL_W'(HOLD_CYCLES - 1)) begin
                        state     <= AxHighRepeat;
                        highPulse <= 1'b1;
                        dwell     <= '0;
                    end
                end
                AxHighRepeat: begin
                    if (!isHigh) begin
                        state <= AxCenter;
                    end else if (dwell == DWELL_W'(REPEAT_CYCLES - 1)) begin
                        highPulse <= 1'b1;
                        dwell     <= '0;
                    end
                end
                default: state <= AxCenter;
            endcase
        end
    end

endmodule

// ==== design/jstkFrameCtrl.sv ====
`timescale 1ns/10ps

module jstkFrameCtrl (
    input  logic        CLK,
    input  logic        RST,
    input  logic        pollReq,
    input  logic        busy,
    input  logic        byteDone,
    input  logic [7:0]  rxByte,
    output logic        byteStart,
    output logic        ss,
    output logic        frameValid,
    output logic [39:0] frame
);
    import joyPkg::*;

    frameState_t           state;
    logic [BYTE_CNT_W-1:0] byteCnt;
    logic [39:0]           acc;     // First byte ends up on top

    // ====================
    // Frame sequencer
    // ====================
    always_ff @(posedge CLK) begin
        if (RST) begin
            state      <= FrmIdle;
            ss         <= 1'b1;
            byteCnt    <= '0;
            frameValid <= 1'b0;
            frame      <= '0;
        end else begin
            frameValid <= 1'b0;
            case (state)
                FrmIdle: begin
                    if (pollReq) begin
                        state   <= FrmStart;
                        ss      <= 1'b0;    // Select slave
                        byteCnt <= '0;
                    end
                end
                FrmStart: begin
                    if (!busy)
                        state <= FrmWait;   // byteStart goes out this cycle
                end
                FrmWait: begin
                    if (byteDone)
                        state <= FrmStore;
                end
                FrmStore: begin
                    byteCnt <= byteCnt + 1'b1;
                    if (byteCnt == BYTE_CNT_W'(FRAME_BYTES - 1))
                        state <= FrmDone;
                    else
                        state <= FrmStart;  // Next byte
                end
                FrmDone: begin
                    ss         <= 1'b1;     // Release slave
                    frame      <= acc;
                    frameValid <= 1'b1;
                    state      <= FrmIdle;
                end
                default: state <= FrmIdle;
            endcase
        end
    end

    // Byte accumulator
    always_ff @(posedge CLK) begin
        if (state == FrmStore)
            acc <= {acc[31:0], rxByte};
    end

    assign byteStart = (state == FrmStart) && !busy;   // Single cycle

endmodule

// ==== design/spiByteEngine.sv ====
`timescale 1ns/10ps

module spiByteEngine (
    input  logic       CLK,
    input  logic       RST,
    input  logic       bitTick,
    input  logic       byteStart,
    input  logic       miso,
    output logic       sclk,
    output logic       mosi,
    output logic       busy,
    output logic       byteDone,
    output logic [7:0] rxByte
);
    import joyPkg::*;

    spiState_t  state;
    logic [2:0] bitCnt;     // Falling edges seen
    logic [7:0] wrSr;       // Write shift register
    logic [7:0] rdSr;       // Read shift register

    // ====================
    // Control FSM
    // ====================
    always_ff @(posedge CLK) begin
        if (RST) begin
            state    <= SpiIdle;
            sclk     <= 1'b0;
            bitCnt   <= '0;
            byteDone <= 1'b0;
        end else begin
            byteDone <= 1'b0;
            case (state)
                SpiIdle: begin
                    bitCnt <= '0;
                    if (byteStart)
                        state <= SpiShift;  // Start ignored unless idle
                end
                SpiShift: begin
                    if (bitTick) begin
                        sclk <= ~sclk;      // Toggle per half bit
                        if (sclk) begin     // Falling edge
                            bitCnt <= bitCnt + 1'b1;
                            if (bitCnt == 3'd7)
                                state <= SpiFinish;  // sclk back low
                        end
                    end
                end
                SpiFinish: begin
                    byteDone <= 1'b1;       // Lands with busy falling
                    state    <= SpiIdle;
                end
                default: state <= SpiIdle;
            endcase
        end
    end

    // Data path, MSB first
    always_ff @(posedge CLK) begin
        if (state == SpiIdle) begin
            wrSr <= 8'h00;                  // MOSI always zero
        end else if (state == SpiShift && bitTick) begin
            if (sclk)
                wrSr <= {wrSr[6:0], 1'b0};  // Change after falling edge
            else
                rdSr <= {rdSr[6:0], miso};  // Sample at rising edge
        end
    end

    assign mosi   = wrSr[7];
    assign busy   = (state != SpiIdle);     // High from cycle after start
    assign rxByte = rdSr;

endmodule

// ==== design/pollTimer.sv ====
`timescale 1ns/10ps

module pollTimer (
    input  logic CLK,
    input  logic RST,
    output logic bitTick,   // One cycle every SCLK_HALF
    output logic pollReq    // One cycle every POLL_CYCLES
);
    import joyPkg::*;

    logic [HALF_W-1:0] halfCnt;
    logic [POLL_W-1:0] pollCnt;

    // Half-bit enable, free running
    always_ff @(posedge CLK) begin
        if (RST) begin
            halfCnt <= '0;
            bitTick <= 1'b0;
        end else if (halfCnt == HALF_W'(SCLK_HALF - 1)) begin
            halfCnt <= '0;
            bitTick <= 1'b1;    // Wrap
        end else begin
            halfCnt <= halfCnt + 1'b1;
            bitTick <= 1'b0;
        end
    end

    // Poll request
    always_ff @(posedge CLK) begin
        if (RST) begin
            pollCnt <= '0;
            pollReq <= 1'b0;
        end else if (pollCnt == POLL_W'(POLL_CYCLES - 1)) begin
            pollCnt <= '0;
            pollReq <= 1'b1;
        end else begin
            pollCnt <= pollCnt + 1'b1;
            pollReq <= 1'b0;
        end
    end

endmodule

// ==== design/joyPkg.sv ====
package joyPkg;

    // ====================
    // Timing, shrunk for simulation
    // ====================
    localparam int SCLK_HALF     = 4;      // CLK cycles per half serial bit
    localparam int POLL_CYCLES   = 800;    // Poll interval, must exceed one frame
    localparam int HALF_W        = $clog2(SCLK_HALF);
    localparam int POLL_W        = $clog2(POLL_CYCLES);

    // Frame layout
    localparam int FRAME_BYTES   = 5;
    localparam int BYTE_CNT_W    = $clog2(FRAME_BYTES);

    // ====================
    // Axis thresholds and repeat
    // ====================
    localparam int POS_W         = 10;
    localparam logic [POS_W-1:0] CENTER_POS = 1 << (POS_W - 1);  // Stick at rest
    localparam int LOW_LIMIT     = 300;    // Below this counts as low
    localparam int HIGH_LIMIT    = 700;    // Above this counts as high
    localparam int HOLD_CYCLES   = 3000;   // First pulse to first repeat
    localparam int REPEAT_CYCLES = 1200;   // Between repeat pulses
    localparam int DWELL_W       = $clog2(HOLD_CYCLES > REPEAT_CYCLES ?
                                          HOLD_CYCLES : REPEAT_CYCLES);

    // FSM states
    typedef enum logic [1:0] {
        SpiIdle,
        SpiShift,
        SpiFinish
    } spiState_t;

    typedef enum logic [2:0] {
        FrmIdle,
        FrmStart,
        FrmWait,
        FrmStore,
        FrmDone
    } frameState_t;

    typedef enum logic [2:0] {
        AxCenter,
        AxLowWait,
        AxLowRepeat,
        AxHighWait,
        AxHighRepeat
    } axisState_t;

    // Bundles
    typedef struct packed {
        logic ss;       // Slave select, active low
        logic sclk;
        logic mosi;
    } spiPins_t;

    typedef struct packed {
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] y;
        logic             trigger;
        logic             thumb;
    } joyState_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } dirPulse_t;

endpackage
